// File: source/rafiCore_params.svh
/*
 * Core-wide sizing constants for the retirement end of the RV32 core.
 * Register file shape, data widths, the trap vector after reset and
 * the depth of the flush window after a redirect.
 */
`ifndef RAFI_CORE_PARAMS_SVH
`define RAFI_CORE_PARAMS_SVH

// Integer data and address width.
`define RAFI_XLEN 32

// Floating-point registers are wide enough for double precision.
`define RAFI_FLEN 64

// Number of architectural registers in each file, and the index width.
`define RAFI_REG_COUNT 32
`define RAFI_REG_ADDR_WIDTH 5

// Where the first trap lands before software programs mtvec.
`define RAFI_MTVEC_RESET 32'h00000100

// One squashed cycle per younger pipeline stage in the full core.
`define RAFI_FLUSH_CYCLES 2

`endif

// File: source/rafiTypes.sv
/*
 * Shared types for the retirement end of the core.
 * Privilege levels, CSR addresses and the packed structs that carry
 * execute results, trap events and register write requests.
 */
`include "rafiCore_params.svh"

package rafiTypes;

    // Encodings follow the RISC-V privileged spec.
    // The value 2'b10 is reserved and never produced by the core.
    typedef enum logic [1:0] {
        userMode       = 2'b00,
        supervisorMode = 2'b01,
        machineMode    = 2'b11
    } privilege_t;

    // Only the trap-related CSRs are implemented.
    typedef enum logic [11:0] {
        csrMstatus = 12'h300,
        csrMtvec   = 12'h305,
        csrMepc    = 12'h341,
        csrMcause  = 12'h342,
        csrMtval   = 12'h343,
        csrSepc    = 12'h141
    } csrAddr_t;

    // Trap raised somewhere upstream and carried along with the instruction.
    typedef struct packed {
        logic                 valid;
        logic [3:0]           cause;
        logic [`RAFI_XLEN-1:0] value;
    } trapInfo_t;

    // Decoded control bits that matter at writeback.
    typedef struct packed {
        logic [`RAFI_REG_ADDR_WIDTH-1:0] rd;
        logic                            intRegWriteEnable;
        logic                            fpRegWriteEnable;
        privilege_t                      trapReturnPrivilege;
    } op_t;

    // One beat from the execute stage.
    // The insn field is kept for tracing and is not decoded here.
    typedef struct packed {
        logic                  valid;
        logic [`RAFI_XLEN-1:0] pc;
        logic [`RAFI_XLEN-1:0] insn;
        op_t                   op;
        logic                  trapReturn;
        trapInfo_t             trapInfo;
        logic [`RAFI_XLEN-1:0] dstIntRegValue;
        logic [`RAFI_FLEN-1:0] dstFpRegValue;
    } execResult_t;

    // Trap or trap return seen at writeback, shared by the CSR unit and
    // the pipeline controller.
    typedef struct packed {
        logic                  trapValid;
        logic [3:0]            cause;
        logic [`RAFI_XLEN-1:0] value;
        logic [`RAFI_XLEN-1:0] pc;
        logic                  returnValid;
        privilege_t            returnPrivilege;
    } trapEvent_t;

    // Write requests into the two register files.
    typedef struct packed {
        logic                            enable;
        logic [`RAFI_REG_ADDR_WIDTH-1:0] addr;
        logic [`RAFI_XLEN-1:0]           value;
    } intRegWrite_t;

    typedef struct packed {
        logic                            enable;
        logic [`RAFI_REG_ADDR_WIDTH-1:0] addr;
        logic [`RAFI_FLEN-1:0]           value;
    } fpRegWrite_t;

endpackage

// File: source/regWriteStage.sv
/*
 * Writeback stage.
 * Decides per beat whether the result commits, traps or is squashed,
 * and turns that into register write requests and a trap event.
 */
`timescale 1ns/1ps
`include "rafiCore_params.svh"

module regWriteStage import rafiTypes::*; (
    input  execResult_t  execResult,
    input  logic         flush,
    output intRegWrite_t intRegWrite,
    output fpRegWrite_t  fpRegWrite,
    output trapEvent_t   trapEvent
);

    logic live;
    logic commit;
    logic trapping;
    op_t  op;

    always_comb begin
        // A beat that arrives inside the flush window belongs to a younger
        // instruction on the wrong path, so it is dropped entirely.
        live = execResult.valid && !flush;
        // A trapping instruction never retires.
        trapping = live && execResult.trapInfo.valid;
        commit = live && !execResult.trapInfo.valid;
        op = execResult.op;
    end

    always_comb begin
        // Both files share the destination index from decode.
        // Only the enable depends on commit.
        intRegWrite.enable = commit && op.intRegWriteEnable;
        intRegWrite.addr = op.rd;
        intRegWrite.value = execResult.dstIntRegValue;

        fpRegWrite.enable = commit && op.fpRegWriteEnable;
        fpRegWrite.addr = op.rd;
        fpRegWrite.value = execResult.dstFpRegValue;
    end

    always_comb begin
        // The trap payload is passed through unqualified.
        // Consumers only look at it when trapValid is set.
        trapEvent.trapValid = trapping;
        trapEvent.cause = execResult.trapInfo.cause;
        trapEvent.value = execResult.trapInfo.value;
        trapEvent.pc = execResult.pc;

        // An xRET that itself traps is handled as the trap, which is why
        // the return is qualified with commit and not with live.
        trapEvent.returnValid = commit && execResult.trapReturn;
        trapEvent.returnPrivilege = op.trapReturnPrivilege;
    end

endmodule

// File: source/regFile.sv
/*
 * Register file with one write port and one combinational read port.
 * Used for both the integer file, where x0 is hardwired to zero, and the
 * double-precision floating-point file.
 */
`timescale 1ns/1ps
`include "rafiCore_params.svh"

module regFile #(
    parameter int dataWidth    = `RAFI_XLEN,
    parameter bit hardwireZero = 1'b1
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            writeEnable,
    input  logic [`RAFI_REG_ADDR_WIDTH-1:0] writeAddr,
    input  logic [dataWidth-1:0]            writeValue,
    input  logic [`RAFI_REG_ADDR_WIDTH-1:0] readAddr,
    output logic [dataWidth-1:0]            readData
);

    logic [dataWidth-1:0] regs [`RAFI_REG_COUNT];
    logic                 writeBlocked;
    logic                 readZero;

    // Writes to entry 0 are discarded when it is the zero register.
    assign writeBlocked = hardwireZero && (writeAddr == '0);

    // The zero register also reads as zero.
    assign readZero = hardwireZero && (readAddr == '0);

    // Every entry is cleared at reset.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `RAFI_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && !writeBlocked) begin
            regs[writeAddr] <= writeValue;
        end
    end

    // Reads are asynchronous.
    // A value written at the end of a beat is visible one cycle later.
    always_comb begin
        if (readZero) begin
            readData = '0;
        end else begin
            readData = regs[readAddr];
        end
    end

endmodule

// File: source/trapCsrUnit.sv
/*
 * Machine trap CSRs and privilege state.
 * Takes traps and trap returns from writeback, serves a CSR read/write
 * port, and supplies the redirect target for the current event.
 */
`timescale 1ns/1ps
`include "rafiCore_params.svh"

module trapCsrUnit import rafiTypes::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  trapEvent_t            trapEvent,
    input  csrAddr_t              csrReadAddr,
    input  logic                  csrWriteEnable,
    input  csrAddr_t              csrWriteAddr,
    input  logic [`RAFI_XLEN-1:0] csrWriteValue,
    output logic [`RAFI_XLEN-1:0] csrReadData,
    output privilege_t            privilege,
    output logic [`RAFI_XLEN-1:0] trapTarget
);

    logic [`RAFI_XLEN-1:0] mtvec;
    logic [`RAFI_XLEN-1:0] mepc;
    logic [`RAFI_XLEN-1:0] mcause;
    logic [`RAFI_XLEN-1:0] mtval;
    logic [`RAFI_XLEN-1:0] sepc;
    privilege_t            mpp;
    logic                  spp;
    logic                  mret;
    logic                  sret;
    logic [1:0]            mppWriteValue;

    // The return flavour comes from the privilege encoded in the opcode.
    assign mret = trapEvent.returnValid && (trapEvent.returnPrivilege == machineMode);
    assign sret = trapEvent.returnValid && (trapEvent.returnPrivilege == supervisorMode);

    // MPP field of an mstatus write.
    assign mppWriteValue = csrWriteValue[12:11];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mtvec <= `RAFI_MTVEC_RESET;
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
            sepc <= '0;
            mpp <= userMode;
            spp <= 1'b0;
            privilege <= machineMode;
        end else begin
            // CSR instruction writes go first.
            // A trap or return in the same cycle overrides what it touches.
            if (csrWriteEnable) begin
                case (csrWriteAddr)
                    csrMstatus: begin
                        // MPP is WARL. The reserved encoding keeps the old value.
                        if (mppWriteValue != 2'b10) begin
                            mpp <= privilege_t'(mppWriteValue);
                        end
                        spp <= csrWriteValue[8];
                    end
                    csrMtvec: mtvec <= csrWriteValue;
                    csrMepc: mepc <= csrWriteValue;
                    csrMcause: mcause <= csrWriteValue;
                    csrMtval: mtval <= csrWriteValue;
                    csrSepc: sepc <= csrWriteValue;
                    default: begin
                    end
                endcase
            end

            if (trapEvent.trapValid) begin
                // All traps are taken in machine mode since there is no delegation.
                mepc <= trapEvent.pc;
                mcause <= {{(`RAFI_XLEN-4){1'b0}}, trapEvent.cause};
                mtval <= trapEvent.value;
                mpp <= privilege;
                privilege <= machineMode;
            end else if (mret) begin
                privilege <= mpp;
                mpp <= userMode;
            end else if (sret) begin
                // SPP only distinguishes user from supervisor.
                privilege <= spp ? supervisorMode : userMode;
                spp <= 1'b0;
            end
        end
    end

    // The target must be ready in the beat cycle, because the controller
    // samples it at the same edge that updates the registers here.
    always_comb begin
        if (trapEvent.trapValid) begin
            trapTarget = mtvec;
        end else if (sret) begin
            trapTarget = sepc;
        end else if (mret) begin
            trapTarget = mepc;
        end else begin
            trapTarget = mtvec;
        end
    end

    always_comb begin
        csrReadData = '0;
        case (csrReadAddr)
            csrMstatus: begin
                // Only MPP and SPP are implemented. The other bits read as zero.
                csrReadData[12:11] = mpp;
                csrReadData[8] = spp;
            end
            csrMtvec: csrReadData = mtvec;
            csrMepc: csrReadData = mepc;
            csrMcause: csrReadData = mcause;
            csrMtval: csrReadData = mtval;
            csrSepc: csrReadData = sepc;
            default: csrReadData = '0;
        endcase
    end

endmodule

// File: source/pipelineController.sv
/*
 * Pipeline controller for traps and trap returns.
 * Issues a one-cycle redirect and holds the flush window that squashes
 * younger results arriving at writeback.
 */
`timescale 1ns/1ps
`include "rafiCore_params.svh"

module pipelineController import rafiTypes::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  trapEvent_t            trapEvent,
    input  logic [`RAFI_XLEN-1:0] trapTarget,
    output logic                  redirectValid,
    output logic [`RAFI_XLEN-1:0] redirectPc,
    output logic                  flush
);

    localparam int countWidth = $clog2(`RAFI_FLUSH_CYCLES + 1);

    logic                  redirectRequest;
    logic [countWidth-1:0] flushCount;

    // Writeback already squashes beats during the window, so an event here
    // never overlaps a redirect in flight.
    assign redirectRequest = trapEvent.trapValid || trapEvent.returnValid;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            redirectValid <= 1'b0;
            flushCount <= '0;
        end else if (redirectRequest) begin
            redirectValid <= 1'b1;
            // The window starts with the redirect cycle itself.
            flushCount <= countWidth'(`RAFI_FLUSH_CYCLES);
        end else begin
            redirectValid <= 1'b0;
            if (flushCount != '0) begin
                flushCount <= flushCount - 1'b1;
            end
        end
    end

    // The target is sampled at the event beat and held until the next one.
    always_ff @(posedge clk) begin
        if (redirectRequest) begin
            redirectPc <= trapTarget;
        end
    end

    assign flush = (flushCount != '0);

endmodule

// File: source/retireCore.sv
/*
 * Retirement end of the core.
 * Connects writeback, the integer and floating-point register files,
 * the trap CSR unit and the pipeline controller.
 */
`timescale 1ns/1ps
`include "rafiCore_params.svh"

module retireCore import rafiTypes::*; (
    input  logic                            clk,
    input  logic                            rstN,
    input  execResult_t                     execResult,
    input  logic [`RAFI_REG_ADDR_WIDTH-1:0] intReadAddr,
    input  logic [`RAFI_REG_ADDR_WIDTH-1:0] fpReadAddr,
    input  csrAddr_t                        csrReadAddr,
    input  logic                            csrWriteEnable,
    input  csrAddr_t                        csrWriteAddr,
    input  logic [`RAFI_XLEN-1:0]           csrWriteValue,
    output logic [`RAFI_XLEN-1:0]           intReadData,
    output logic [`RAFI_FLEN-1:0]           fpReadData,
    output logic [`RAFI_XLEN-1:0]           csrReadData,
    output privilege_t                      privilege,
    output logic                            redirectValid,
    output logic [`RAFI_XLEN-1:0]           redirectPc
);

    logic                  flush;
    intRegWrite_t          intRegWrite;
    fpRegWrite_t           fpRegWrite;
    trapEvent_t            trapEvent;
    logic [`RAFI_XLEN-1:0] trapTarget;

    regWriteStage regWriteStage_i (
        .execResult (execResult),
        .flush      (flush),
        .intRegWrite(intRegWrite),
        .fpRegWrite (fpRegWrite),
        .trapEvent  (trapEvent)
    );

    // Integer file with x0 hardwired to zero.
    regFile #(.dataWidth(`RAFI_XLEN), .hardwireZero(1'b1)) intRegFile (
        .clk        (clk),
        .rstN       (rstN),
        .writeEnable(intRegWrite.enable),
        .writeAddr  (intRegWrite.addr),
        .writeValue (intRegWrite.value),
        .readAddr   (intReadAddr),
        .readData   (intReadData)
    );

    // Floating-point file where f0 is an ordinary register.
    regFile #(.dataWidth(`RAFI_FLEN), .hardwireZero(1'b0)) fpRegFile (
        .clk        (clk),
        .rstN       (rstN),
        .writeEnable(fpRegWrite.enable),
        .writeAddr  (fpRegWrite.addr),
        .writeValue (fpRegWrite.value),
        .readAddr   (fpReadAddr),
        .readData   (fpReadData)
    );

    trapCsrUnit trapCsrUnit_i (
        .clk           (clk),
        .rstN          (rstN),
        .trapEvent     (trapEvent),
        .csrReadAddr   (csrReadAddr),
        .csrWriteEnable(csrWriteEnable),
        .csrWriteAddr  (csrWriteAddr),
        .csrWriteValue (csrWriteValue),
        .csrReadData   (csrReadData),
        .privilege     (privilege),
        .trapTarget    (trapTarget)
    );

    pipelineController pipelineController_i (
        .clk          (clk),
        .rstN         (rstN),
        .trapEvent    (trapEvent),
        .trapTarget   (trapTarget),
        .redirectValid(redirectValid),
        .redirectPc   (redirectPc),
        .flush        (flush)
    );

endmodule

// File: dv/retireTb.sv
/*
 * Testbench for the retirement end of the core.
 * Plays a trace of execute beats, CSR writes and expected outputs into
 * retireCore and checks register, CSR, privilege and redirect responses.
 */
`timescale 1ns/1ps
`include "rafiCore_params.svh"

module retireTb import rafiTypes::*; ();

    localparam int redirectTimeout = 20;

    logic                            clk;
    logic                            rstN;
    execResult_t                     execResult;
    logic [`RAFI_REG_ADDR_WIDTH-1:0] intReadAddr;
    logic [`RAFI_REG_ADDR_WIDTH-1:0] fpReadAddr;
    csrAddr_t                        csrReadAddr;
    logic                            csrWriteEnable;
    csrAddr_t                        csrWriteAddr;
    logic [`RAFI_XLEN-1:0]           csrWriteValue;
    logic [`RAFI_XLEN-1:0]           intReadData;
    logic [`RAFI_FLEN-1:0]           fpReadData;
    logic [`RAFI_XLEN-1:0]           csrReadData;
    privilege_t                      privilege;
    logic                            redirectValid;
    logic [`RAFI_XLEN-1:0]           redirectPc;

    // The trace fills these values, and the next rising edge applies them together.
    execResult_t                     pendBeat;
    logic                            pendWriteEnable;
    csrAddr_t                        pendWriteAddr;
    logic [`RAFI_XLEN-1:0]           pendWriteValue;
    logic [`RAFI_REG_ADDR_WIDTH-1:0] pendIntAddr;
    logic [`RAFI_REG_ADDR_WIDTH-1:0] pendFpAddr;
    csrAddr_t                        pendCsrAddr;

    int            traceFile;
    int            code;
    int            seedValue;
    int            errorCount;
    int            checkCount;
    int            testCount;
    int            failedTests;
    int            testStartErrors;
    int            idleCycles;
    bit            testOpen;
    bit            aborted;
    bit            done;
    reg [8*16-1:0] kind;
    reg [8*16-1:0] outName;
    reg [8*32-1:0] testName;
    reg [8*256-1:0] restOfLine;
    logic [63:0]   bPc;
    logic [63:0]   bInsn;
    logic [63:0]   bRd;
    logic [63:0]   bIntWe;
    logic [63:0]   bFpWe;
    logic [63:0]   bRetPriv;
    logic [63:0]   bTrapRet;
    logic [63:0]   bTrapValid;
    logic [63:0]   bCause;
    logic [63:0]   bValue;
    logic [63:0]   bIntVal;
    logic [63:0]   bFpVal;
    logic [63:0]   addrValue;
    logic [63:0]   expectedValue;

    retireCore retireCore_i (
        .clk           (clk),
        .rstN          (rstN),
        .execResult    (execResult),
        .intReadAddr   (intReadAddr),
        .fpReadAddr    (fpReadAddr),
        .csrReadAddr   (csrReadAddr),
        .csrWriteEnable(csrWriteEnable),
        .csrWriteAddr  (csrWriteAddr),
        .csrWriteValue (csrWriteValue),
        .intReadData   (intReadData),
        .fpReadData    (fpReadData),
        .csrReadData   (csrReadData),
        .privilege     (privilege),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc)
    );

    // 40 ns clock period.
    always #20 clk = ~clk;

    task automatic checkValue(input [8*16-1:0] name, input logic [63:0] expected,
                              input logic [63:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %0s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // An empty slot carries random pc and insn, but valid stays low.
    function automatic execResult_t makeIdleBeat();
        execResult_t beat;
        beat = '0;
        beat.pc = $urandom;
        beat.insn = $urandom;
        return beat;
    endfunction

    // Drives one clock cycle. Inputs change at the rising edge, and the task
    // returns at the falling edge where every output has settled.
    task automatic driveCycle();
        @(posedge clk);
        execResult <= pendBeat;
        csrWriteEnable <= pendWriteEnable;
        csrWriteAddr <= pendWriteAddr;
        csrWriteValue <= pendWriteValue;
        intReadAddr <= pendIntAddr;
        fpReadAddr <= pendFpAddr;
        csrReadAddr <= pendCsrAddr;
        // Beats and CSR writes last a single cycle; read addresses persist.
        pendBeat = makeIdleBeat();
        pendWriteEnable = 1'b0;
        @(negedge clk);
    endtask

    task automatic checkOutput(input [8*16-1:0] name, input logic [63:0] expected);
        case (name)
            "intReadData": checkValue(name, expected, intReadData);
            "fpReadData": checkValue(name, expected, fpReadData);
            "csrReadData": checkValue(name, expected, csrReadData);
            "privilege": checkValue(name, expected, privilege);
            "redirectValid": checkValue(name, expected, redirectValid);
            "redirectPc": checkValue(name, expected, redirectPc);
            default: begin
                aborted = 1'b1;
                $display("the trace names an output that does not exist: %0s", name);
            end
        endcase
    endtask

    // Points one read port at an address for a cycle and checks what it returns.
    task automatic checkReadPort(input [8*16-1:0] port, input logic [63:0] addr,
                                 input logic [63:0] expected);
        case (port)
            "intReadData": pendIntAddr = addr[`RAFI_REG_ADDR_WIDTH-1:0];
            "fpReadData": pendFpAddr = addr[`RAFI_REG_ADDR_WIDTH-1:0];
            "csrReadData": pendCsrAddr = csrAddr_t'(addr[11:0]);
            default: begin
            end
        endcase
        driveCycle();
        checkOutput(port, expected);
    endtask

    // The current cycle counts, so a redirect that is already up is seen at once.
    task automatic waitRedirect(input logic [63:0] expectedPc);
        int cycles;
        cycles = 0;
        while (redirectValid !== 1'b1 && cycles < redirectTimeout) begin
            driveCycle();
            cycles++;
        end
        if (redirectValid === 1'b1) begin
            checkValue("redirectPc", expectedPc, redirectPc);
        end else begin
            aborted = 1'b1;
            $display("no redirect arrived within %0d cycles", redirectTimeout);
        end
    endtask

    task automatic closeTest();
        if (testOpen) begin
            testCount++;
            if (errorCount == testStartErrors && !aborted) begin
                $display("test %0s: ok", testName);
            end else begin
                failedTests++;
                $display("test %0s: %0d errors", testName, errorCount - testStartErrors);
            end
        end
        testOpen = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        execResult = '0;
        intReadAddr = '0;
        fpReadAddr = '0;
        csrReadAddr = csrMstatus;
        csrWriteEnable = 1'b0;
        csrWriteAddr = csrMstatus;
        csrWriteValue = '0;
        pendWriteEnable = 1'b0;
        pendWriteAddr = csrMstatus;
        pendWriteValue = '0;
        pendIntAddr = '0;
        pendFpAddr = '0;
        pendCsrAddr = csrMstatus;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        failedTests = 0;
        testStartErrors = 0;
        testOpen = 1'b0;
        aborted = 1'b0;
        done = 1'b0;
        seedValue = $urandom(42756);
        pendBeat = makeIdleBeat();

        // Reset is held over five rising edges.
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);

        traceFile = $fopen("dv/retireTrace.txt", "r");
        if (traceFile == 0) begin
            aborted = 1'b1;
            $display("could not open the trace file dv/retireTrace.txt");
        end

        while (!done && !aborted) begin
            code = $fscanf(traceFile, "%s", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(restOfLine, traceFile);
            end else if (kind == "T") begin
                closeTest();
                code = $fscanf(traceFile, "%s", testName);
                testOpen = 1'b1;
                testStartErrors = errorCount;
            end else if (kind == "B") begin
                code = $fscanf(traceFile, "%h %h %h %h %h %h %h %h %h %h %h %h",
                               bPc, bInsn, bRd, bIntWe, bFpWe, bRetPriv,
                               bTrapRet, bTrapValid, bCause, bValue, bIntVal, bFpVal);
                pendBeat = '0;
                pendBeat.valid = 1'b1;
                pendBeat.pc = bPc[31:0];
                pendBeat.insn = bInsn[31:0];
                pendBeat.op.rd = bRd[`RAFI_REG_ADDR_WIDTH-1:0];
                pendBeat.op.intRegWriteEnable = bIntWe[0];
                pendBeat.op.fpRegWriteEnable = bFpWe[0];
                pendBeat.op.trapReturnPrivilege = privilege_t'(bRetPriv[1:0]);
                pendBeat.trapReturn = bTrapRet[0];
                pendBeat.trapInfo.valid = bTrapValid[0];
                pendBeat.trapInfo.cause = bCause[3:0];
                pendBeat.trapInfo.value = bValue[31:0];
                pendBeat.dstIntRegValue = bIntVal[31:0];
                pendBeat.dstFpRegValue = bFpVal;
                driveCycle();
            end else if (kind == "I") begin
                code = $fscanf(traceFile, "%d", idleCycles);
                repeat (idleCycles) driveCycle();
            end else if (kind == "W") begin
                code = $fscanf(traceFile, "%h %h", addrValue, expectedValue);
                pendWriteEnable = 1'b1;
                pendWriteAddr = csrAddr_t'(addrValue[11:0]);
                pendWriteValue = expectedValue[31:0];
                driveCycle();
            end else if (kind == "R") begin
                code = $fscanf(traceFile, "%s %h %h", outName, addrValue, expectedValue);
                checkReadPort(outName, addrValue, expectedValue);
            end else if (kind == "C") begin
                code = $fscanf(traceFile, "%s %h", outName, expectedValue);
                checkOutput(outName, expectedValue);
            end else if (kind == "V") begin
                code = $fscanf(traceFile, "%h", expectedValue);
                waitRedirect(expectedValue);
            end else begin
                aborted = 1'b1;
                $display("the trace holds a record of unknown kind %0s", kind);
            end
        end
        closeTest();

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0 && !aborted && testCount > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: rafiWriteback.f
+incdir+source
source/rafiTypes.sv
source/regWriteStage.sv
source/regFile.sv
source/trapCsrUnit.sv
source/pipelineController.sv
source/retireCore.sv
dv/retireTb.sv

// File: dv/retireTrace.txt
# T name | I cycles | W csrAddr value | R port addr expected | C output expected | V redirectPc
# B pc insn rd intWe fpWe retPriv trapReturn trapValid cause value intValue fpValue (all hex)
T resetValues
C privilege 3
C redirectValid 0
R csrReadData 305 00000100
T regWrites
I 2
B 00001000 00000013 05 1 0 0 0 0 0 00000000 deadbeef 0000000000000000
R intReadData 05 deadbeef
B 00001004 00000053 03 0 1 0 0 0 0 00000000 00000000 3ff0000000000000
R fpReadData 03 3ff0000000000000
B 00001008 00000013 00 1 1 0 0 0 0 00000000 12345678 4000000000000000
R intReadData 00 00000000
R fpReadData 00 4000000000000000
T trapBeat
B 00002000 ffffffff 07 1 1 0 0 1 2 ffffffff 0badf00d 1111111111111111
V 00000100
C privilege 3
R intReadData 07 00000000
R fpReadData 07 0000000000000000
R csrReadData 341 00002000
R csrReadData 342 00000002
R csrReadData 343 ffffffff
T flushWindow
B 00003000 00000013 00 0 0 0 0 1 3 00003000 00000000 0000000000000000
B 00003004 00000013 0a 1 1 0 0 0 0 00000000 0000aaaa 000000000000aaaa
V 00000100
B 00003008 00000013 0b 1 0 0 0 1 5 00000000 0000bbbb 0000000000000000
C redirectValid 0
B 0000300c 00000013 0c 1 0 0 0 0 0 00000000 0000cccc 0000000000000000
C redirectValid 0
R intReadData 0a 00000000
R fpReadData 0a 0000000000000000
R intReadData 0b 00000000
R intReadData 0c 0000cccc
R csrReadData 342 00000003
T mret
W 341 00004000
W 300 00000800
R csrReadData 300 00000800
B 00005000 30200073 00 0 0 3 1 0 0 00000000 00000000 0000000000000000
V 00004000
C privilege 1
R csrReadData 300 00000000
T sret
W 141 00006000
W 300 00000000
B 00007000 10200073 00 0 0 1 1 0 0 00000000 00000000 0000000000000000
V 00006000
C privilege 0
T trapOverReturn
I 2
B 00008000 10200073 00 0 0 1 1 1 2 10200073 00000000 0000000000000000
V 00000100
C privilege 3
R csrReadData 341 00008000
R csrReadData 342 00000002
R csrReadData 300 00000000
